// ==== hw/exec_pkg.sv ====
// execute subsystem shared definitions
// datapath width, operation encodings, the secondary opcode union
// and the records passed between the operand and commit stages
package exec_pkg;

  localparam int XLEN      = 32;
  // wide enough to count XLEN divide steps
  localparam int DIV_CNT_W = 6;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  typedef enum logic [3:0] {
    KIND_ADD,
    KIND_LOGIC,
    KIND_CMOV,
    KIND_MOVHI,
    KIND_SHIFT,
    KIND_FFL1,
    KIND_SETFLAG,
    KIND_MUL,
    KIND_DIV,
    KIND_NOP
  } op_kind_e;

  typedef enum logic [1:0] {
    LOGIC_AND,
    LOGIC_OR,
    LOGIC_XOR
  } logic_opc_e;

  // or1k sfxx condition codes where the signed forms have bit 3 set
  typedef enum logic [3:0] {
    CMP_EQ  = 4'h0,
    CMP_NE  = 4'h1,
    CMP_GTU = 4'h2,
    CMP_GEU = 4'h3,
    CMP_LTU = 4'h4,
    CMP_LEU = 4'h5,
    CMP_GTS = 4'ha,
    CMP_GES = 4'hb,
    CMP_LTS = 4'hc,
    CMP_LES = 4'hd
  } cmp_opc_e;

  typedef enum logic [1:0] {
    SHIFT_SLL,
    SHIFT_SRL,
    SHIFT_SRA,
    SHIFT_ROR
  } shift_opc_e;

  // shift and ffl1 view of the secondary opcode
  typedef struct packed {
    logic       spare;
    logic       last;
    shift_opc_e opc;
  } shift_sec_t;

  // setflag reads a condition, shift and ffl1 read the struct
  typedef union packed {
    cmp_opc_e   cmp;
    shift_sec_t shift;
  } opc_sec_u;

  // --------------------------------------------------
  // stage records
  // --------------------------------------------------
  typedef struct packed {
    logic [XLEN-1:0] rfa;
    logic [XLEN-1:0] rfb;
    logic [XLEN-1:0] imm;
    logic            imm_sel;
    op_kind_e        kind;
    logic_opc_e      logic_opc;
    opc_sec_u        sec;
    logic            do_sub;
    logic            do_carry;
    logic            div_signed;
  } dec_op_t;

  typedef struct packed {
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    op_kind_e        kind;
    logic_opc_e      logic_opc;
    opc_sec_u        sec;
    logic            do_sub;
    logic            do_carry;
    logic            div_signed;
  } exe_op_t;

  typedef struct packed {
    logic flag_set;
    logic flag_clr;
    logic carry_set;
    logic carry_clr;
    logic ovf_set;
    logic ovf_clr;
  } flag_upd_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            flag;
    logic            carry;
    logic            overflow;
  } wb_t;

endpackage

// ==== hw/exec_operand_stage.sv ====
`timescale 1ns/1ps
// execute operand stage
// captures the decoded operation on the decode strobe, resolves
// operand b from the immediate or the register file value and
// keeps the occupancy flag of the stage
module exec_operand_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              padv_decode_i,
  input  logic              padv_wb_i,
  input  logic              flush_i,
  input  exec_pkg::dec_op_t dec_i,
  output exec_pkg::exe_op_t op_o,
  output logic              op_valid_o
);
  import exec_pkg::*;

  logic [XLEN-1:0] opb_sel;
  logic            drop;

  // operand b source
  assign opb_sel = dec_i.imm_sel ? dec_i.imm : dec_i.rfb;

  // stage empties on commit or flush
  assign drop = padv_wb_i | flush_i;

  // --------------------------------------------------
  // operation payload
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (padv_decode_i) begin
      op_o.a          <= dec_i.rfa;
      op_o.b          <= opb_sel;
      op_o.imm        <= dec_i.imm;
      op_o.kind       <= dec_i.kind;
      op_o.logic_opc  <= dec_i.logic_opc;
      op_o.sec        <= dec_i.sec;
      op_o.do_sub     <= dec_i.do_sub;
      op_o.do_carry   <= dec_i.do_carry;
      op_o.div_signed <= dec_i.div_signed;
    end
  end

  // --------------------------------------------------
  // occupancy
  // --------------------------------------------------
  // a new decode wins over a commit or flush in the same cycle,
  // so back-to-back issue keeps the stage full
  always_ff @(posedge clk) begin
    if (rst) begin
      op_valid_o <= 1'b0;
    end else if (padv_decode_i) begin
      op_valid_o <= 1'b1;
    end else if (drop) begin
      op_valid_o <= 1'b0;
    end
  end

endmodule

// ==== hw/exec_alu.sv ====
`timescale 1ns/1ps
// single-cycle integer ALU
// one adder serves add, sub, add-with-carry and the compares; also
// holds the logic table, barrel shifter, ffl1, cmov and movhi, and
// drives the flag, carry and overflow updates
module exec_alu (
  input  exec_pkg::exe_op_t         op_i,
  input  logic                      flag_i,
  input  logic                      carry_i,
  output logic [exec_pkg::XLEN-1:0] result_o,
  output exec_pkg::flag_upd_t       upd_o
);
  import exec_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic            is_add;
  logic            is_setflag;
  logic            sub_en;
  logic            carry_in;
  logic [XLEN-1:0] b_mux;
  logic [XLEN-1:0] adder_sum;
  logic            adder_cout;
  logic            adder_ovf;
  logic            adder_carry;
  logic            a_eq_b;
  logic            a_ltu_b;
  logic            a_lts_b;
  logic            cmp_flag;
  logic [3:0]      logic_lut;
  logic [XLEN-1:0] logic_res;
  shift_opc_e      sh_opc;
  logic [XLEN-1:0] sh_lsw;
  logic [XLEN-1:0] sh_msw;
  logic [2*XLEN-1:0] sh_wide;
  logic [XLEN-1:0] sh_right;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] ffl1_res;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[XLEN-1-i] = v[i];
    end
    return r;
  endfunction

  assign a          = op_i.a;
  assign b          = op_i.b;
  assign is_add     = (op_i.kind == KIND_ADD);
  assign is_setflag = (op_i.kind == KIND_SETFLAG);

  // --------------------------------------------------
  // adder and compare
  // --------------------------------------------------
  // compares always run as a - b
  assign sub_en   = op_i.do_sub | is_setflag;
  assign b_mux    = sub_en ? ~b : b;
  assign carry_in = sub_en | (op_i.do_carry & carry_i);
  assign {adder_cout, adder_sum} = a + b_mux + {{(XLEN-1){1'b0}}, carry_in};

  // same input signs, different result sign
  assign adder_ovf   = (a[XLEN-1] == b_mux[XLEN-1]) & (a[XLEN-1] ^ adder_sum[XLEN-1]);
  // borrow on subtract
  assign adder_carry = sub_en ? ~adder_cout : adder_cout;

  assign a_eq_b  = (adder_sum == '0);
  assign a_ltu_b = ~adder_cout;
  assign a_lts_b = adder_sum[XLEN-1] ^ adder_ovf;

  always_comb begin
    case (op_i.sec.cmp)
      CMP_EQ:  cmp_flag = a_eq_b;
      CMP_NE:  cmp_flag = ~a_eq_b;
      CMP_GTU: cmp_flag = ~(a_eq_b | a_ltu_b);
      CMP_GTS: cmp_flag = ~(a_eq_b | a_lts_b);
      CMP_GEU: cmp_flag = ~a_ltu_b;
      CMP_GES: cmp_flag = ~a_lts_b;
      CMP_LTU: cmp_flag = a_ltu_b;
      CMP_LTS: cmp_flag = a_lts_b;
      CMP_LEU: cmp_flag = a_eq_b | a_ltu_b;
      CMP_LES: cmp_flag = a_eq_b | a_lts_b;
      default: cmp_flag = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // logic table indexed per bit by {a, b}
  // --------------------------------------------------
  always_comb begin
    case (op_i.logic_opc)
      LOGIC_AND: logic_lut = 4'b1000;
      LOGIC_OR:  logic_lut = 4'b1110;
      LOGIC_XOR: logic_lut = 4'b0110;
      default:   logic_lut = 4'b0000;
    endcase
    for (int i = 0; i < XLEN; i++) begin
      logic_res[i] = logic_lut[{a[i], b[i]}];
    end
  end

  // --------------------------------------------------
  // shifter with left shift done as a reversed right shift
  // --------------------------------------------------
  assign sh_opc    = op_i.sec.shift.opc;
  assign sh_lsw    = (sh_opc == SHIFT_SLL) ? bit_rev(a) : a;
  assign sh_msw    = (sh_opc == SHIFT_SRA) ? {XLEN{a[XLEN-1]}} :
                     (sh_opc == SHIFT_ROR) ? a : '0;
  assign sh_wide   = {sh_msw, sh_lsw} >> b[4:0];
  assign sh_right  = sh_wide[XLEN-1:0];
  assign shift_res = (sh_opc == SHIFT_SLL) ? bit_rev(sh_right) : sh_right;

  // ffl1 gives the bit index plus one, or zero when a is zero
  always_comb begin
    ffl1_res = '0;
    if (op_i.sec.shift.last) begin
      for (int i = 0; i < XLEN; i++) begin
        if (a[i]) ffl1_res = XLEN'(i + 1);
      end
    end else begin
      for (int i = XLEN - 1; i >= 0; i--) begin
        if (a[i]) ffl1_res = XLEN'(i + 1);
      end
    end
  end

  // add and setflag fall through to the adder result
  always_comb begin
    case (op_i.kind)
      KIND_LOGIC: result_o = logic_res;
      KIND_CMOV:  result_o = flag_i ? a : b;
      KIND_MOVHI: result_o = {op_i.imm[15:0], 16'h0000};
      KIND_SHIFT: result_o = shift_res;
      KIND_FFL1:  result_o = ffl1_res;
      default:    result_o = adder_sum;
    endcase
  end

  assign upd_o.flag_set  = is_setflag & cmp_flag;
  assign upd_o.flag_clr  = is_setflag & ~cmp_flag;
  assign upd_o.carry_set = is_add & adder_carry;
  assign upd_o.carry_clr = is_add & ~adder_carry;
  assign upd_o.ovf_set   = is_add & adder_ovf;
  assign upd_o.ovf_clr   = is_add & ~adder_ovf;

endmodule

// ==== hw/exec_muldiv.sv ====
`timescale 1ns/1ps
// multi-cycle multiply and divide
// 3-stage multiplier tracked by a one-hot shift counter, and a
// 32-step restoring divider with sign fix-up and divide-by-zero
// detection; both restart on a new decode or a flush
module exec_muldiv (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      padv_decode_i,
  input  logic                      flush_i,
  input  exec_pkg::exe_op_t         op_i,
  input  logic                      op_valid_i,
  output logic [exec_pkg::XLEN-1:0] result_o,
  output logic                      valid_o,
  output logic                      div_by_zero_o
);
  import exec_pkg::*;

  logic                 restart;
  logic                 is_mul;
  logic                 is_div;
  logic [XLEN-1:0]      mul_opa;
  logic [XLEN-1:0]      mul_opb;
  logic [XLEN-1:0]      mul_p1;
  logic [XLEN-1:0]      mul_p2;
  logic [2:0]           mul_cnt;
  logic                 mul_done;
  logic [DIV_CNT_W-1:0] div_cnt;
  logic                 div_done;
  logic                 div_start;
  logic                 div_busy;
  logic                 div_neg;
  logic                 div_dbz;
  logic [XLEN-1:0]      div_n;
  logic [XLEN-1:0]      div_d;
  logic [XLEN-1:0]      div_r;
  logic [XLEN:0]        div_shift;
  logic [XLEN+1:0]      div_sub;
  logic [XLEN-1:0]      div_quot;

  assign restart = padv_decode_i | flush_i;
  assign is_mul  = op_valid_i & (op_i.kind == KIND_MUL);
  assign is_div  = op_valid_i & (op_i.kind == KIND_DIV);

  // --------------------------------------------------
  // multiplier
  // --------------------------------------------------
  assign mul_done = mul_cnt[2];

  always_ff @(posedge clk) begin
    if (is_mul && (mul_cnt == 3'd0)) begin
      mul_opa <= op_i.a;
      mul_opb <= op_i.b;
    end
    mul_p1 <= mul_opa * mul_opb;
    mul_p2 <= mul_p1;
  end

  // one bit walks up with the product
  always_ff @(posedge clk) begin
    if (rst) begin
      mul_cnt <= 3'd0;
    end else if (restart) begin
      mul_cnt <= 3'd0;
    end else if (mul_cnt == 3'd0) begin
      mul_cnt <= {2'b00, is_mul};
    end else if (!mul_done) begin
      mul_cnt <= {mul_cnt[1:0], 1'b0};
    end
  end

  // --------------------------------------------------
  // divider
  // --------------------------------------------------
  assign div_start = is_div && (div_cnt == '0);
  assign div_busy  = (div_cnt != '0) && !div_done;
  assign div_shift = {div_r, div_n[XLEN-1]};
  assign div_sub   = {1'b0, div_shift} - {2'b00, div_d};

  // counter holds at 1 once done so the operation does not restart
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt  <= '0;
      div_done <= 1'b0;
    end else if (restart) begin
      div_cnt  <= '0;
      div_done <= 1'b0;
    end else if (div_start) begin
      div_cnt  <= DIV_CNT_W'(XLEN);
    end else if (div_busy && (div_cnt == DIV_CNT_W'(1))) begin
      div_done <= 1'b1;
    end else if (div_busy) begin
      div_cnt  <= div_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      // magnitudes only with the sign restored on the quotient
      div_n   <= (op_i.div_signed && op_i.a[XLEN-1]) ? -op_i.a : op_i.a;
      div_d   <= (op_i.div_signed && op_i.b[XLEN-1]) ? -op_i.b : op_i.b;
      div_r   <= '0;
      div_neg <= op_i.div_signed && (op_i.a[XLEN-1] ^ op_i.b[XLEN-1]);
      div_dbz <= (op_i.b == '0);
    end else if (div_busy) begin
      if (!div_sub[XLEN+1]) begin
        div_r <= div_sub[XLEN-1:0];
        div_n <= {div_n[XLEN-2:0], 1'b1};
      end else begin
        div_r <= div_shift[XLEN-1:0];
        div_n <= {div_n[XLEN-2:0], 1'b0};
      end
    end
  end

  assign div_quot = div_neg ? -div_n : div_n;

  assign result_o      = (op_i.kind == KIND_MUL) ? mul_p2 : div_quot;
  assign valid_o       = (op_i.kind == KIND_MUL) ? mul_done : div_done;
  assign div_by_zero_o = div_dbz;

endmodule

// ==== hw/exec_commit_stage.sv ====
`timescale 1ns/1ps
// execute commit stage
// picks the ALU or muldiv result, signals when the execute result is
// ready, registers it on the writeback strobe and keeps the
// architectural flag, carry and overflow bits
module exec_commit_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      padv_wb_i,
  input  logic                      flush_i,
  input  exec_pkg::op_kind_e        op_kind_i,
  input  logic                      div_signed_i,
  input  logic                      op_valid_i,
  input  logic [exec_pkg::XLEN-1:0] alu_result_i,
  input  exec_pkg::flag_upd_t       alu_upd_i,
  input  logic [exec_pkg::XLEN-1:0] md_result_i,
  input  logic                      md_valid_i,
  input  logic                      div_by_zero_i,
  output logic                      exec_valid_o,
  output logic                      flag_o,
  output logic                      carry_o,
  output exec_pkg::wb_t             wb_o,
  output logic                      wb_valid_o
);
  import exec_pkg::*;

  logic            is_div;
  logic            is_md;
  logic            commit;
  logic [XLEN-1:0] result;
  flag_upd_t       upd;
  logic            flag_d;
  logic            carry_d;
  logic            ovf_d;
  logic            flag_q;
  logic            carry_q;
  logic            ovf_q;
  logic [XLEN-1:0] result_q;

  assign is_div = (op_kind_i == KIND_DIV);
  assign is_md  = (op_kind_i == KIND_MUL) | is_div;
  assign result = is_md ? md_result_i : alu_result_i;

  // mul and div hold the stage until muldiv is done
  assign exec_valid_o = op_valid_i & (~is_md | md_valid_i);
  assign commit       = padv_wb_i & exec_valid_o & ~flush_i;

  // divide by zero reports on overflow when signed, carry when not
  always_comb begin
    upd = alu_upd_i;
    if (is_div && div_signed_i) begin
      upd.ovf_set = div_by_zero_i;
      upd.ovf_clr = ~div_by_zero_i;
    end else if (is_div) begin
      upd.carry_set = div_by_zero_i;
      upd.carry_clr = ~div_by_zero_i;
    end
  end

  assign flag_d  = upd.flag_set | (flag_q & ~upd.flag_clr);
  assign carry_d = upd.carry_set | (carry_q & ~upd.carry_clr);
  assign ovf_d   = upd.ovf_set | (ovf_q & ~upd.ovf_clr);

  always_ff @(posedge clk) begin
    if (rst) begin
      flag_q     <= 1'b0;
      carry_q    <= 1'b0;
      ovf_q      <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= commit;
      if (commit) begin
        flag_q  <= flag_d;
        carry_q <= carry_d;
        ovf_q   <= ovf_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit) result_q <= result;
  end

  assign wb_o    = '{result: result_q, flag: flag_q, carry: carry_q, overflow: ovf_q};
  assign flag_o  = flag_q;
  assign carry_o = carry_q;

endmodule

// ==== hw/exec_top.sv ====
`timescale 1ns/1ps
// integer execute subsystem top
// operand stage, ALU, multiplier/divider and commit stage, with the
// committed flag and carry fed back into the ALU
module exec_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              padv_decode_i,
  input  logic              padv_wb_i,
  input  logic              flush_i,
  input  exec_pkg::dec_op_t dec_i,
  output logic              exec_valid_o,
  output exec_pkg::wb_t     wb_o,
  output logic              wb_valid_o
);
  import exec_pkg::*;

  exe_op_t         op;
  logic            op_valid;
  logic [XLEN-1:0] alu_result;
  flag_upd_t       alu_upd;
  logic [XLEN-1:0] md_result;
  logic            md_valid;
  logic            div_by_zero;
  logic            flag;
  logic            carry;

  exec_operand_stage u_operand_stage (
    .clk           (clk),
    .rst           (rst),
    .padv_decode_i (padv_decode_i),
    .padv_wb_i     (padv_wb_i),
    .flush_i       (flush_i),
    .dec_i         (dec_i),
    .op_o          (op),
    .op_valid_o    (op_valid)
  );

  exec_alu u_alu (
    .op_i     (op),
    .flag_i   (flag),
    .carry_i  (carry),
    .result_o (alu_result),
    .upd_o    (alu_upd)
  );

  exec_muldiv u_muldiv (
    .clk           (clk),
    .rst           (rst),
    .padv_decode_i (padv_decode_i),
    .flush_i       (flush_i),
    .op_i          (op),
    .op_valid_i    (op_valid),
    .result_o      (md_result),
    .valid_o       (md_valid),
    .div_by_zero_o (div_by_zero)
  );

  // committed flag and carry go back to cmov and add-with-carry
  exec_commit_stage u_commit_stage (
    .clk           (clk),
    .rst           (rst),
    .padv_wb_i     (padv_wb_i),
    .flush_i       (flush_i),
    .op_kind_i     (op.kind),
    .div_signed_i  (op.div_signed),
    .op_valid_i    (op_valid),
    .alu_result_i  (alu_result),
    .alu_upd_i     (alu_upd),
    .md_result_i   (md_result),
    .md_valid_i    (md_valid),
    .div_by_zero_i (div_by_zero),
    .exec_valid_o  (exec_valid_o),
    .flag_o        (flag),
    .carry_o       (carry),
    .wb_o          (wb_o),
    .wb_valid_o    (wb_valid_o)
  );

endmodule

// ==== verification/exec_tb.sv ====
`timescale 1ns/1ps
// testbench for the integer execute subsystem
// builds a table of directed and random operations whose expected
// results come from a reference model, then runs each row through
// the decode, execute and writeback strobes and checks the commit
module exec_tb;
  import exec_pkg::*;

  typedef struct packed {
    dec_op_t dec;
    logic    do_flush;
    logic    chk_res;
    wb_t     exp;
  } row_t;

  logic        clk;
  logic        rst;
  logic        padv_decode;
  logic        padv_wb;
  logic        flush;
  dec_op_t     dec;
  logic        exec_valid;
  wb_t         wb;
  logic        wb_valid;

  row_t        rows[$];
  cmp_opc_e    cmp_codes [10];
  logic [31:0] lcg_state;
  logic        m_flag;
  logic        m_carry;
  logic        m_ovf;
  int          errors;
  int          checks;
  int          cycles;
  int          cycle_limit;

  exec_top UUT (
    .clk           (clk),
    .rst           (rst),
    .padv_decode_i (padv_decode),
    .padv_wb_i     (padv_wb),
    .flush_i       (flush),
    .dec_i         (dec),
    .exec_valid_o  (exec_valid),
    .wb_o          (wb),
    .wb_valid_o    (wb_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog over the whole run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // --------------------------------------------------
  // reference model of one operation against the flag state
  // --------------------------------------------------
  function automatic void model(input dec_op_t d, input logic f, input logic c,
                                input logic o, output logic [31:0] r,
                                output logic nf, output logic nc, output logic no,
                                output logic chk);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [32:0] wide;
    logic        cin;
    longint      sa;
    longint      sb;
    longint      s64;
    longint      sr;
    a   = d.rfa;
    b   = d.imm_sel ? d.imm : d.rfb;
    sh  = b[4:0];
    sa  = $signed(a);
    sb  = $signed(b);
    cin = d.do_carry & c;
    r   = '0;
    nf  = f;
    nc  = c;
    no  = o;
    chk = 1'b1;
    case (d.kind)
      KIND_ADD: begin
        if (d.do_sub) begin
          s64 = sa - sb;
          r   = a - b;
          // carry is the borrow
          nc  = (a < b);
        end else begin
          s64  = sa + sb + longint'(cin);
          wide = {1'b0, a} + {1'b0, b} + {32'b0, cin};
          r    = wide[31:0];
          nc   = wide[32];
        end
        sr = $signed(r);
        no = (s64 != sr);
      end
      KIND_LOGIC: begin
        case (d.logic_opc)
          LOGIC_OR:  r = a | b;
          LOGIC_XOR: r = a ^ b;
          default:   r = a & b;
        endcase
      end
      KIND_CMOV:  r = f ? a : b;
      KIND_MOVHI: r = {d.imm[15:0], 16'h0000};
      KIND_SHIFT: begin
        case (d.sec.shift.opc)
          SHIFT_SLL: r = a << sh;
          SHIFT_SRL: r = a >> sh;
          SHIFT_SRA: r = $signed(a) >>> sh;
          default:   r = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
        endcase
      end
      KIND_FFL1: begin
        if (d.sec.shift.last) begin
          for (int i = 31; i >= 0; i--) begin
            if (a[i] && r == '0) r = 32'(i + 1);
          end
        end else begin
          for (int i = 0; i < 32; i++) begin
            if (a[i] && r == '0) r = 32'(i + 1);
          end
        end
      end
      KIND_SETFLAG: begin
        chk = 1'b0;
        case (d.sec.cmp)
          CMP_EQ:  nf = (a == b);
          CMP_NE:  nf = (a != b);
          CMP_GTU: nf = (a > b);
          CMP_GTS: nf = (sa > sb);
          CMP_GEU: nf = (a >= b);
          CMP_GES: nf = (sa >= sb);
          CMP_LTU: nf = (a < b);
          CMP_LTS: nf = (sa < sb);
          CMP_LEU: nf = (a <= b);
          CMP_LES: nf = (sa <= sb);
          default: nf = f;
        endcase
      end
      KIND_MUL: r = a * b;
      KIND_DIV: begin
        if (b == '0) begin
          // quotient is undefined here
          chk = 1'b0;
          if (d.div_signed) no = 1'b1;
          else nc = 1'b1;
        end else if (d.div_signed) begin
          s64 = sa / sb;
          r   = s64[31:0];
          no  = 1'b0;
        end else begin
          r  = a / b;
          nc = 1'b0;
        end
      end
      default: chk = 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // table construction
  // --------------------------------------------------
  function automatic void append_row(input dec_op_t d, input logic fl);
    row_t rw;
    rw          = '0;
    rw.dec      = d;
    rw.do_flush = fl;
    if (fl) begin
      // flushed work leaves the state alone
      rw.exp.flag     = m_flag;
      rw.exp.carry    = m_carry;
      rw.exp.overflow = m_ovf;
    end else begin
      model(d, m_flag, m_carry, m_ovf, rw.exp.result, rw.exp.flag, rw.exp.carry,
            rw.exp.overflow, rw.chk_res);
      m_flag  = rw.exp.flag;
      m_carry = rw.exp.carry;
      m_ovf   = rw.exp.overflow;
    end
    rows.push_back(rw);
  endfunction

  // ctl is {do_sub, do_carry, div_signed}
  function automatic void add_row(input op_kind_e kind, input logic [31:0] a,
                                  input logic [31:0] b, input logic [3:0] sec,
                                  input logic [2:0] ctl, input logic fl);
    dec_op_t d;
    d           = '0;
    d.kind      = kind;
    d.rfa       = a;
    d.rfb       = b;
    d.imm       = b;
    d.sec       = opc_sec_u'(sec);
    d.logic_opc = (kind == KIND_LOGIC) ? logic_opc_e'(sec[1:0]) : LOGIC_AND;
    {d.do_sub, d.do_carry, d.div_signed} = ctl;
    append_row(d, fl);
  endfunction

  function automatic void rand_row();
    dec_op_t     d;
    logic [31:0] x;
    int          sel;
    x         = next_rand();
    d         = '0;
    d.rfa     = next_rand();
    d.rfb     = next_rand();
    d.imm     = next_rand();
    d.imm_sel = x[15];
    sel       = int'(x[31:16] % 16'd11);
    d.do_sub   = (sel == 1);
    d.do_carry = (sel == 2);
    case (sel)
      0, 1, 2: d.kind = KIND_ADD;
      3:       d.kind = KIND_LOGIC;
      4:       d.kind = KIND_CMOV;
      5:       d.kind = KIND_MOVHI;
      6:       d.kind = KIND_SHIFT;
      7:       d.kind = KIND_FFL1;
      8:       d.kind = KIND_SETFLAG;
      9:       d.kind = KIND_MUL;
      default: d.kind = KIND_DIV;
    endcase
    d.logic_opc  = logic_opc_e'(x[9:8] % 2'd3);
    d.div_signed = x[7];
    case (d.kind)
      KIND_SHIFT:   d.sec = opc_sec_u'({2'b00, x[9:8]});
      KIND_FFL1:    d.sec = opc_sec_u'({1'b0, x[10], 2'b00});
      KIND_SETFLAG: d.sec = opc_sec_u'(cmp_codes[x[23:16] % 8'd10]);
      default:      d.sec = opc_sec_u'(4'h0);
    endcase
    // smaller divisors and now and then equal or zero operands
    if (d.kind == KIND_DIV) begin
      d.imm_sel = 1'b0;
      d.rfb     = d.rfb >> x[20:16];
    end
    if (x[14:12] == 3'd0) begin
      d.imm_sel = 1'b0;
      d.rfb     = d.rfa;
    end
    if (x[14:12] == 3'd1) d.rfa = '0;
    append_row(d, 1'b0);
  endfunction

  function automatic void build_table();
    m_flag  = 1'b0;
    m_carry = 1'b0;
    m_ovf   = 1'b0;
    // add, sub and add with carry
    add_row(KIND_ADD, 32'd5,         32'd7,         4'h0, 3'b000, 1'b0);
    add_row(KIND_ADD, 32'hffff_ffff, 32'd1,         4'h0, 3'b000, 1'b0);
    add_row(KIND_ADD, 32'd10,        32'd20,        4'h0, 3'b010, 1'b0);
    add_row(KIND_ADD, 32'h7fff_ffff, 32'd1,         4'h0, 3'b000, 1'b0);
    add_row(KIND_ADD, 32'd3,         32'd5,         4'h0, 3'b100, 1'b0);
    add_row(KIND_ADD, 32'h7fff_ffff, 32'd0,         4'h0, 3'b010, 1'b0);
    add_row(KIND_ADD, 32'h8000_0000, 32'd1,         4'h0, 3'b100, 1'b0);
    // compares on edge operands with cmov after some of them
    add_row(KIND_SETFLAG, 32'd5,         32'd5,         4'(CMP_EQ),  3'b000, 1'b0);
    add_row(KIND_CMOV,    32'h0000_aaaa, 32'h0000_5555, 4'h0,        3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'd5,         32'd5,         4'(CMP_NE),  3'b000, 1'b0);
    add_row(KIND_CMOV,    32'h0000_aaaa, 32'h0000_5555, 4'h0,        3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'hffff_ffff, 32'd1,         4'(CMP_GTU), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'hffff_ffff, 32'd1,         4'(CMP_GTS), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'd7,         32'd7,         4'(CMP_GEU), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'h8000_0000, 32'h7fff_ffff, 4'(CMP_GES), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'd0,         32'd1,         4'(CMP_LTU), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'h8000_0000, 32'd0,         4'(CMP_LTS), 3'b000, 1'b0);
    add_row(KIND_CMOV,    32'h1234_5678, 32'h8765_4321, 4'h0,        3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'd2,         32'd1,         4'(CMP_LEU), 3'b000, 1'b0);
    add_row(KIND_SETFLAG, 32'hffff_ffff, 32'hffff_ffff, 4'(CMP_LES), 3'b000, 1'b0);
    // logic, shifts, ffl1 and movhi
    add_row(KIND_LOGIC, 32'hf0f0_ff00, 32'h0ff0_f0f0, 4'(LOGIC_AND), 3'b000, 1'b0);
    add_row(KIND_LOGIC, 32'hf0f0_ff00, 32'h0ff0_f0f0, 4'(LOGIC_OR),  3'b000, 1'b0);
    add_row(KIND_LOGIC, 32'hf0f0_ff00, 32'h0ff0_f0f0, 4'(LOGIC_XOR), 3'b000, 1'b0);
    add_row(KIND_SHIFT, 32'd1,         32'd31,        4'(SHIFT_SLL), 3'b000, 1'b0);
    add_row(KIND_SHIFT, 32'h8000_0000, 32'd4,         4'(SHIFT_SRL), 3'b000, 1'b0);
    add_row(KIND_SHIFT, 32'h8000_0000, 32'd4,         4'(SHIFT_SRA), 3'b000, 1'b0);
    add_row(KIND_SHIFT, 32'h1234_5678, 32'd8,         4'(SHIFT_ROR), 3'b000, 1'b0);
    add_row(KIND_SHIFT, 32'h1234_5678, 32'd32,        4'(SHIFT_ROR), 3'b000, 1'b0);
    add_row(KIND_FFL1,  32'h0000_00f0, 32'd0,         4'b0000,       3'b000, 1'b0);
    add_row(KIND_FFL1,  32'h0000_00f0, 32'd0,         4'b0100,       3'b000, 1'b0);
    add_row(KIND_FFL1,  32'd0,         32'd0,         4'b0100,       3'b000, 1'b0);
    add_row(KIND_FFL1,  32'h8000_0000, 32'd0,         4'b0000,       3'b000, 1'b0);
    add_row(KIND_MOVHI, 32'd0,         32'h1234_abcd, 4'h0,          3'b000, 1'b0);
    // multiply and divide
    add_row(KIND_MUL, 32'h0001_0000, 32'h0001_0001, 4'h0, 3'b000, 1'b0);
    add_row(KIND_MUL, 32'hffff_fffd, 32'd7,         4'h0, 3'b000, 1'b0);
    add_row(KIND_DIV, 32'hffff_fff9, 32'd2,         4'h0, 3'b001, 1'b0);
    add_row(KIND_DIV, 32'hffff_ffff, 32'd16,        4'h0, 3'b000, 1'b0);
    add_row(KIND_DIV, 32'd100,       32'hffff_fff9, 4'h0, 3'b001, 1'b0);
    add_row(KIND_DIV, 32'd42,        32'd0,         4'h0, 3'b001, 1'b0);
    add_row(KIND_DIV, 32'd42,        32'd0,         4'h0, 3'b000, 1'b0);
    add_row(KIND_DIV, 32'd9,         32'd3,         4'h0, 3'b000, 1'b0);
    // a divide dropped by a flush and one that completes after it
    add_row(KIND_DIV, 32'd77,        32'd0,         4'h0, 3'b000, 1'b1);
    add_row(KIND_DIV, 32'd1000,      32'd7,         4'h0, 3'b000, 1'b0);
    repeat (200) rand_row();
  endfunction

  // --------------------------------------------------
  // checks and row execution
  // --------------------------------------------------
  function automatic void compare_field(input int row, input string what,
                                        input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: row %0d %s is %h, expected %h", $time, row, what, got, exp);
    end
  endfunction

  task automatic run_row(input int i);
    row_t rw;
    rw          = rows[i];
    dec         = rw.dec;
    padv_decode = 1'b1;
    @(negedge clk);
    padv_decode = 1'b0;
    if (rw.do_flush) begin
      // let the divider start, then drop it
      repeat (3) @(negedge clk);
      if (exec_valid) begin
        errors++;
        $display("row %0d: divide reported done before it could have finished", i);
      end
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      // watch for longer than a whole divide would take
      repeat (40) begin
        if (wb_valid || exec_valid) begin
          errors++;
          $display("row %0d: flushed operation still produced a result", i);
        end
        @(negedge clk);
      end
    end else begin
      while (!exec_valid) @(negedge clk);
      padv_wb = 1'b1;
      @(negedge clk);
      padv_wb = 1'b0;
      if (!wb_valid) begin
        errors++;
        $display("row %0d: no writeback one cycle after the writeback strobe", i);
      end
      if (rw.chk_res) compare_field(i, "result", wb.result, rw.exp.result);
    end
    compare_field(i, "flag", 32'(wb.flag), 32'(rw.exp.flag));
    compare_field(i, "carry", 32'(wb.carry), 32'(rw.exp.carry));
    compare_field(i, "overflow", 32'(wb.overflow), 32'(rw.exp.overflow));
  endtask

  initial begin
    rst         = 1'b1;
    padv_decode = 1'b0;
    padv_wb     = 1'b0;
    flush       = 1'b0;
    dec         = '0;
    lcg_state   = 32'h06e1_db1b;
    cmp_codes   = '{CMP_EQ, CMP_NE, CMP_GTU, CMP_GTS, CMP_GEU,
                    CMP_GES, CMP_LTU, CMP_LTS, CMP_LEU, CMP_LES};
    build_table();
    cycle_limit = 40 * rows.size() + 100;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    checks++;
    if (exec_valid || wb_valid || wb.flag || wb.carry || wb.overflow) begin
      errors++;
      $display("Error at %0t ns: outputs not cleared by reset", $time);
    end
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/exec_pkg.sv
hw/exec_operand_stage.sv
hw/exec_alu.sv
hw/exec_muldiv.sv
hw/exec_commit_stage.sv
hw/exec_top.sv
verification/exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the execute subsystem testbench with Verilator and runs it
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -Wno-fatal --top-module exec_tb -f list.f -o exec_tb_sim

./obj_dir/exec_tb_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0
